//--- filelist.f
+incdir+common
common/pipe_pkg.sv
fetch/ifetch.sv
decode/idec.sv
execute/ex.sv
memory/mem_stage.sv
source/pipeline.sv
bench/tb_models.sv
bench/tb_pipeline.sv

//--- bench/tb_pipeline.sv
`timescale 1ns/10ps
`include "pipe_macros.svh"

module tb_pipeline;
  import pipe_pkg::*;

  localparam int NUM_ROWS    = 26;
  localparam int WATCHDOG_NS = 20 * (20 * NUM_ROWS + 200);

  localparam logic [5:0] OPC_SPECIAL = 6'h00;
  localparam logic [5:0] OPC_ADDIU   = 6'h09;
  localparam logic [5:0] OPC_ANDI    = 6'h0c;
  localparam logic [5:0] OPC_ORI     = 6'h0d;
  localparam logic [5:0] OPC_LUI     = 6'h0f;
  localparam logic [5:0] OPC_LW      = 6'h23;
  localparam logic [5:0] OPC_SW      = 6'h2b;
  localparam logic [5:0] FN_ADDU     = 6'h21;
  localparam logic [5:0] FN_SUBU     = 6'h23;
  localparam logic [5:0] FN_AND      = 6'h24;
  localparam logic [5:0] FN_OR       = 6'h25;
  localparam logic [5:0] FN_XOR      = 6'h26;
  localparam logic [5:0] FN_SLT      = 6'h2a;
  localparam logic [5:0] FN_SLTU     = 6'h2b;

  typedef struct packed {
    reg_addr_t addr;
    word_t     data;
  } write_rec_t;

  typedef struct packed {
    word_t addr;
    word_t data;
  } store_rec_t;

  logic                  clock;
  logic                  rst;
  word_t                 icache_addr;
  logic                  icache_rd;
  word_t                 icache_data;
  logic                  icache_wait;
  reg_addr_t             rfile_rd_addr1;
  reg_addr_t             rfile_rd_addr2;
  word_t                 rfile_rd_data1;
  word_t                 rfile_rd_data2;
  word_t                 dcache_addr;
  logic                  dcache_rd;
  logic                  dcache_wr;
  word_t                 dcache_wr_data;
  logic [`PIPE_BE_W-1:0] dcache_wr_be;
  word_t                 dcache_data;
  logic                  dcache_wait;
  reg_addr_t             rfile_wr_addr;
  logic                  rfile_wr_enable;
  word_t                 rfile_wr_data;

  word_t      prog [NUM_ROWS];
  write_rec_t exp_writes[$];
  store_rec_t exp_stores[$];
  int         wr_count;
  int         st_count;

  pipeline dut (
    .clock_i              (clock),
    .rst_i                (rst),
    .icache_addr_o        (icache_addr),
    .icache_rd_o          (icache_rd),
    .icache_data_i        (icache_data),
    .icache_waitrequest_i (icache_wait),
    .rfile_rd_addr1_o     (rfile_rd_addr1),
    .rfile_rd_addr2_o     (rfile_rd_addr2),
    .rfile_rd_data1_i     (rfile_rd_data1),
    .rfile_rd_data2_i     (rfile_rd_data2),
    .dcache_addr_o        (dcache_addr),
    .dcache_rd_o          (dcache_rd),
    .dcache_wr_o          (dcache_wr),
    .dcache_wr_data_o     (dcache_wr_data),
    .dcache_wr_be_o       (dcache_wr_be),
    .dcache_data_i        (dcache_data),
    .dcache_waitrequest_i (dcache_wait),
    .rfile_wr_addr_o      (rfile_wr_addr),
    .rfile_wr_enable_o    (rfile_wr_enable),
    .rfile_wr_data_o      (rfile_wr_data)
  );

  tb_models u_models (
    .clock_i              (clock),
    .icache_addr_i        (icache_addr),
    .icache_data_o        (icache_data),
    .icache_waitrequest_o (icache_wait),
    .rfile_rd_addr1_i     (rfile_rd_addr1),
    .rfile_rd_addr2_i     (rfile_rd_addr2),
    .rfile_rd_data1_o     (rfile_rd_data1),
    .rfile_rd_data2_o     (rfile_rd_data2),
    .dcache_addr_i        (dcache_addr),
    .dcache_wr_i          (dcache_wr),
    .dcache_wr_data_i     (dcache_wr_data),
    .dcache_data_o        (dcache_data),
    .dcache_waitrequest_o (dcache_wait),
    .rfile_wr_addr_i      (rfile_wr_addr),
    .rfile_wr_enable_i    (rfile_wr_enable),
    .rfile_wr_data_i      (rfile_wr_data)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic word_t r_word(input logic [5:0] fn, input reg_addr_t rs,
                                   input reg_addr_t rt, input reg_addr_t rd);
    return {OPC_SPECIAL, rs, rt, rd, 5'h00, fn};
  endfunction

  function automatic word_t i_word(input logic [5:0] op, input reg_addr_t rs,
                                   input reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic build_program();
    prog[0]  = i_word(OPC_ADDIU, 0, 1, 16'hfff0);
    prog[1]  = r_word(FN_ADDU, 1, 5, 2);
    prog[2]  = r_word(FN_SUBU, 2, 1, 3);
    prog[3]  = r_word(FN_AND, 3, 2, 4);
    prog[4]  = r_word(FN_OR, 4, 7, 6);
    prog[5]  = r_word(FN_XOR, 6, 2, 8);
    prog[6]  = r_word(FN_SLT, 8, 4, 9);
    prog[7]  = r_word(FN_SLTU, 8, 4, 10);
    prog[8]  = i_word(OPC_ANDI, 2, 11, 16'h8001);
    prog[9]  = i_word(OPC_ORI, 11, 12, 16'hf000);
    prog[10] = i_word(OPC_LUI, 0, 13, 16'habcd);
    // r0 destination, no write
    prog[11] = r_word(FN_ADDU, 13, 12, 0);
    prog[12] = i_word(OPC_ORI, 0, 14, 16'h0040);
    prog[13] = i_word(OPC_SW, 14, 13, 16'h0008);
    prog[14] = i_word(OPC_SW, 14, 12, 16'h000c);
    // Loads with a dependent right behind
    prog[15] = i_word(OPC_LW, 14, 15, 16'h0008);
    prog[16] = r_word(FN_ADDU, 15, 9, 16);
    prog[17] = i_word(OPC_LW, 14, 17, 16'h000c);
    prog[18] = r_word(FN_SUBU, 17, 16, 18);
    prog[19] = i_word(OPC_SW, 14, 18, 16'h0000);
    prog[20] = i_word(OPC_LW, 14, 19, 16'h0000);
    prog[21] = i_word(OPC_SW, 14, 19, 16'h0004);
    prog[22] = 32'hfc00_0000;
    prog[23] = r_word(FN_SLT, 1, 3, 20);
    prog[24] = r_word(FN_SLTU, 1, 3, 0);
    prog[25] = i_word(OPC_ADDIU, 18, 22, 16'hffff);
  endtask

  // ISA model over the program, in order
  task automatic compute_reference();
    word_t      regs [32];
    word_t      dmem [256];
    word_t      w;
    word_t      a;
    word_t      b;
    word_t      res;
    word_t      addr;
    word_t      sext;
    word_t      zext;
    reg_addr_t  dst;
    logic       wr;
    write_rec_t wrec;
    store_rec_t srec;
    int         i;
    for (i = 0; i < 32; i++) begin
      regs[i] = 3 * i;
    end
    for (i = 0; i < 256; i++) begin
      dmem[i] = '0;
    end
    for (i = 0; i < NUM_ROWS; i++) begin
      w    = prog[i];
      a    = regs[w[25:21]];
      b    = regs[w[20:16]];
      sext = {{16{w[15]}}, w[15:0]};
      zext = {16'h0000, w[15:0]};
      addr = a + sext;
      dst  = w[20:16];
      wr   = 1'b1;
      res  = '0;
      case (w[31:26])
        OPC_SPECIAL: begin
          dst = w[15:11];
          case (w[5:0])
            FN_ADDU: res = a + b;
            FN_SUBU: res = a - b;
            FN_AND:  res = a & b;
            FN_OR:   res = a | b;
            FN_XOR:  res = a ^ b;
            FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            default: wr = 1'b0;
          endcase
        end
        OPC_ADDIU: res = a + sext;
        OPC_ANDI:  res = a & zext;
        OPC_ORI:   res = a | zext;
        OPC_LUI:   res = {w[15:0], 16'h0000};
        OPC_LW:    res = dmem[addr[9:2]];
        OPC_SW: begin
          wr = 1'b0;
          dmem[addr[9:2]] = b;
          srec.addr = addr;
          srec.data = b;
          exp_stores.push_back(srec);
        end
        default: wr = 1'b0;
      endcase
      if (wr && dst != '0) begin
        regs[dst] = res;
        wrec.addr = dst;
        wrec.data = res;
        exp_writes.push_back(wrec);
      end
    end
  endtask

  task automatic end_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_write(input reg_addr_t got_addr, input word_t got_data,
                             input reg_addr_t exp_addr, input word_t exp_data);
    if (got_addr !== exp_addr || got_data !== exp_data) begin
      $display("MISMATCH at time %0t: register write r%0d <= %h, expected r%0d <= %h",
               $time, got_addr, got_data, exp_addr, exp_data);
      end_with_failure();
    end
  endtask

  task automatic check_store(input word_t got_addr, input word_t got_data,
                             input logic [`PIPE_BE_W-1:0] got_be,
                             input word_t exp_addr, input word_t exp_data);
    if (got_addr !== exp_addr || got_data !== exp_data || got_be !== '1) begin
      $display("MISMATCH at time %0t: store [%h] <= %h be %b, expected [%h] <= %h be all ones",
               $time, got_addr, got_data, got_be, exp_addr, exp_data);
      end_with_failure();
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("MISMATCH at time %0t: %s is %h, expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at time %0t: %s is %b, expected %b", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clock) begin : monitor
    write_rec_t exp_w;
    store_rec_t exp_s;
    if (!rst) begin
      if (rfile_wr_enable === 1'b1) begin
        if (rfile_wr_addr == '0) begin
          $display("Register r0 was written at time %0t", $time);
          end_with_failure();
        end else if (wr_count >= exp_writes.size()) begin
          $display("Extra register write to r%0d at time %0t", rfile_wr_addr, $time);
          end_with_failure();
        end else begin
          exp_w = exp_writes[wr_count];
          check_write(rfile_wr_addr, rfile_wr_data, exp_w.addr, exp_w.data);
          wr_count++;
        end
      end
      if (dcache_wr === 1'b1 && dcache_wait === 1'b0) begin
        if (st_count >= exp_stores.size()) begin
          $display("Extra store to address %h at time %0t", dcache_addr, $time);
          end_with_failure();
        end else begin
          exp_s = exp_stores[st_count];
          check_store(dcache_addr, dcache_wr_data, dcache_wr_be, exp_s.addr, exp_s.data);
          st_count++;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns: not all expected writes and stores appeared",
             WATCHDOG_NS);
    end_with_failure();
  end

  initial begin : main
    int i;
    rst      = 1'b1;
    wr_count = 0;
    st_count = 0;
    build_program();
    compute_reference();
    @(posedge clock);
    for (i = 0; i < NUM_ROWS; i++) begin
      u_models.load_word(i, prog[i]);
    end
    @(posedge clock);
    rst <= 1'b0;

    // Quiet outputs until the first writeback
    @(negedge clock);
    check_word("icache_addr_o", icache_addr, `PIPE_RESET_PC);
    check_bit("icache_rd_o", icache_rd, 1'b1);
    check_bit("rfile_wr_enable_o", rfile_wr_enable, 1'b0);
    while (rfile_wr_enable !== 1'b1) begin
      check_bit("dcache_rd_o", dcache_rd, 1'b0);
      check_bit("dcache_wr_o", dcache_wr, 1'b0);
      @(negedge clock);
    end

    while (wr_count < exp_writes.size() || st_count < exp_stores.size()) begin
      @(posedge clock);
    end

    // Let the pipeline drain, anything further is a repeat
    repeat (40) @(posedge clock);
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- bench/tb_models.sv
`timescale 1ns/10ps

module tb_models (
  input  logic                clock_i,
  input  pipe_pkg::word_t     icache_addr_i,
  output pipe_pkg::word_t     icache_data_o,
  output logic                icache_waitrequest_o,
  input  pipe_pkg::reg_addr_t rfile_rd_addr1_i,
  input  pipe_pkg::reg_addr_t rfile_rd_addr2_i,
  output pipe_pkg::word_t     rfile_rd_data1_o,
  output pipe_pkg::word_t     rfile_rd_data2_o,
  input  pipe_pkg::word_t     dcache_addr_i,
  input  logic                dcache_wr_i,
  input  pipe_pkg::word_t     dcache_wr_data_i,
  output pipe_pkg::word_t     dcache_data_o,
  output logic                dcache_waitrequest_o,
  input  pipe_pkg::reg_addr_t rfile_wr_addr_i,
  input  logic                rfile_wr_enable_i,
  input  pipe_pkg::word_t     rfile_wr_data_i
);
  import pipe_pkg::*;

  localparam int ROM_WORDS = 64;
  localparam int RAM_WORDS = 256;

  word_t rom  [ROM_WORDS];
  word_t ram  [RAM_WORDS];
  word_t regs [32];

  initial begin : fill
    int i;
    for (i = 0; i < ROM_WORDS; i++) begin
      rom[i] = '0;
    end
    for (i = 0; i < RAM_WORDS; i++) begin
      ram[i] = '0;
    end
    // Register n starts at 3n
    for (i = 0; i < 32; i++) begin
      regs[i] = 3 * i;
    end
  end

  // One wait in three on each cache
  initial begin
    icache_waitrequest_o = 1'b0;
    dcache_waitrequest_o = 1'b0;
    void'($urandom(32'he212));
    forever begin
      @(posedge clock_i);
      icache_waitrequest_o <= ($urandom % 3) == 0;
      dcache_waitrequest_o <= ($urandom % 3) == 0;
    end
  end

  // Past the ROM everything reads as zero, a bubble
  assign icache_data_o    = (icache_addr_i < 4 * ROM_WORDS) ? rom[icache_addr_i[7:2]] : '0;
  assign dcache_data_o    = ram[dcache_addr_i[9:2]];
  assign rfile_rd_data1_o = regs[rfile_rd_addr1_i];
  assign rfile_rd_data2_o = regs[rfile_rd_addr2_i];

  always @(posedge clock_i) begin
    if (rfile_wr_enable_i && rfile_wr_addr_i != '0) begin
      regs[rfile_wr_addr_i] <= rfile_wr_data_i;
    end
    if (dcache_wr_i && !dcache_waitrequest_o) begin
      ram[dcache_addr_i[9:2]] <= dcache_wr_data_i;
    end
  end

  task automatic load_word(input int index, input word_t value);
    rom[index] = value;
  endtask

endmodule

//--- source/pipeline.sv
`timescale 1ns/10ps
`include "pipe_macros.svh"

module pipeline (
  input  logic                  clock_i,
  input  logic                  rst_i,

  output pipe_pkg::word_t       icache_addr_o,
  output logic                  icache_rd_o,
  input  pipe_pkg::word_t       icache_data_i,
  input  logic                  icache_waitrequest_i,

  output pipe_pkg::reg_addr_t   rfile_rd_addr1_o,
  output pipe_pkg::reg_addr_t   rfile_rd_addr2_o,
  input  pipe_pkg::word_t       rfile_rd_data1_i,
  input  pipe_pkg::word_t       rfile_rd_data2_i,

  output pipe_pkg::word_t       dcache_addr_o,
  output logic                  dcache_rd_o,
  output logic                  dcache_wr_o,
  output pipe_pkg::word_t       dcache_wr_data_o,
  output logic [`PIPE_BE_W-1:0] dcache_wr_be_o,
  input  pipe_pkg::word_t       dcache_data_i,
  input  logic                  dcache_waitrequest_i,

  output pipe_pkg::reg_addr_t   rfile_wr_addr_o,
  output logic                  rfile_wr_enable_o,
  output pipe_pkg::word_t       rfile_wr_data_o
);
  import pipe_pkg::*;

  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t mem_wb;

  logic load_use;
  logic mem_stall;
  logic ex_hold;
  logic id_hold;
  logic if_hold;

  // A dcache wait freezes everything up to EX/MEM
  assign ex_hold = mem_stall;
  // Load-use holds the front end while ID/EX takes a bubble
  assign id_hold = mem_stall | load_use;
  assign if_hold = id_hold;

  ifetch u_ifetch (
    .clock_i              (clock_i),
    .rst_i                (rst_i),
    .hold_i               (if_hold),
    .icache_data_i        (icache_data_i),
    .icache_waitrequest_i (icache_waitrequest_i),
    .icache_addr_o        (icache_addr_o),
    .icache_rd_o          (icache_rd_o),
    .if_id_o              (if_id)
  );

  // idec inserts its own bubble on load-use, so only the memory hold freezes ID/EX
  idec u_idec (
    .clock_i          (clock_i),
    .rst_i            (rst_i),
    .hold_i           (ex_hold),
    .if_id_i          (if_id),
    .rfile_rd_data1_i (rfile_rd_data1_i),
    .rfile_rd_data2_i (rfile_rd_data2_i),
    .mem_wb_i         (mem_wb),
    .rfile_rd_addr1_o (rfile_rd_addr1_o),
    .rfile_rd_addr2_o (rfile_rd_addr2_o),
    .load_use_o       (load_use),
    .id_ex_o          (id_ex)
  );

  ex u_ex (
    .clock_i  (clock_i),
    .rst_i    (rst_i),
    .hold_i   (ex_hold),
    .id_ex_i  (id_ex),
    .ex_mem_i (ex_mem),
    .mem_wb_i (mem_wb),
    .ex_mem_o (ex_mem)
  );

  mem_stage u_mem_stage (
    .clock_i              (clock_i),
    .rst_i                (rst_i),
    .ex_mem_i             (ex_mem),
    .dcache_data_i        (dcache_data_i),
    .dcache_waitrequest_i (dcache_waitrequest_i),
    .dcache_addr_o        (dcache_addr_o),
    .dcache_rd_o          (dcache_rd_o),
    .dcache_wr_o          (dcache_wr_o),
    .dcache_wr_data_o     (dcache_wr_data_o),
    .dcache_wr_be_o       (dcache_wr_be_o),
    .mem_stall_o          (mem_stall),
    .mem_wb_o             (mem_wb),
    .rfile_wr_addr_o      (rfile_wr_addr_o),
    .rfile_wr_enable_o    (rfile_wr_enable_o),
    .rfile_wr_data_o      (rfile_wr_data_o)
  );

endmodule

//--- memory/mem_stage.sv
`timescale 1ns/10ps
`include "pipe_macros.svh"

module mem_stage (
  input  logic                  clock_i,
  input  logic                  rst_i,
  input  pipe_pkg::ex_mem_t     ex_mem_i,
  input  pipe_pkg::word_t       dcache_data_i,
  input  logic                  dcache_waitrequest_i,
  output pipe_pkg::word_t       dcache_addr_o,
  output logic                  dcache_rd_o,
  output logic                  dcache_wr_o,
  output pipe_pkg::word_t       dcache_wr_data_o,
  output logic [`PIPE_BE_W-1:0] dcache_wr_be_o,
  output logic                  mem_stall_o,
  output pipe_pkg::mem_wb_t     mem_wb_o,
  output pipe_pkg::reg_addr_t   rfile_wr_addr_o,
  output logic                  rfile_wr_enable_o,
  output pipe_pkg::word_t       rfile_wr_data_o
);
  import pipe_pkg::*;

  mem_wb_t mem_wb_q;

  assign dcache_addr_o    = ex_mem_i.result;
  assign dcache_rd_o      = ex_mem_i.cls == CLS_LOAD;
  assign dcache_wr_o      = ex_mem_i.cls == CLS_STORE;
  assign dcache_wr_data_o = ex_mem_i.st_data;
  // Word stores only
  assign dcache_wr_be_o   = {`PIPE_BE_W{1'b1}};
  assign mem_stall_o      = (dcache_rd_o | dcache_wr_o) & dcache_waitrequest_i;

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      mem_wb_q.dest_valid <= 1'b0;
    end else begin
      mem_wb_q.dest_valid <= ex_mem_i.dest_valid & ~mem_stall_o;
      mem_wb_q.dest       <= ex_mem_i.dest;
      mem_wb_q.result     <= dcache_rd_o ? dcache_data_i : ex_mem_i.result;
    end
  end

  assign mem_wb_o          = mem_wb_q;
  assign rfile_wr_addr_o   = mem_wb_q.dest;
  assign rfile_wr_enable_o = mem_wb_q.dest_valid;
  assign rfile_wr_data_o   = mem_wb_q.result;

  a_rd_wr_excl: assert property (@(posedge clock_i) disable iff (rst_i)
    !(dcache_rd_o && dcache_wr_o));

  // EX/MEM is frozen while the dcache waits
  a_stall_stable: assert property (@(posedge clock_i) disable iff (rst_i)
    mem_stall_o |=> $stable(dcache_addr_o) && $stable(dcache_wr_data_o) &&
                    $stable(dcache_rd_o) && $stable(dcache_wr_o));

endmodule

//--- execute/ex.sv
`timescale 1ns/10ps

module ex (
  input  logic              clock_i,
  input  logic              rst_i,
  input  logic              hold_i,
  input  pipe_pkg::id_ex_t  id_ex_i,
  input  pipe_pkg::ex_mem_t ex_mem_i,
  input  pipe_pkg::mem_wb_t mem_wb_i,
  output pipe_pkg::ex_mem_t ex_mem_o
);
  import pipe_pkg::*;

  logic    exm_hit_a;
  logic    exm_hit_b;
  logic    wb_hit_a;
  logic    wb_hit_b;
  logic    exm_is_alu;
  word_t   rs_val;
  word_t   rt_val;
  word_t   alu_b;
  word_t   alu_res;
  ex_mem_t ex_mem_q;

  assign exm_hit_a  = id_ex_i.src_a_used && ex_mem_i.dest_valid &&
                      ex_mem_i.dest == id_ex_i.src_a;
  assign exm_hit_b  = id_ex_i.src_b_used && ex_mem_i.dest_valid &&
                      ex_mem_i.dest == id_ex_i.src_b;
  assign wb_hit_a   = id_ex_i.src_a_used && mem_wb_i.dest_valid &&
                      mem_wb_i.dest == id_ex_i.src_a;
  assign wb_hit_b   = id_ex_i.src_b_used && mem_wb_i.dest_valid &&
                      mem_wb_i.dest == id_ex_i.src_b;
  assign exm_is_alu = ex_mem_i.cls == CLS_ALU;

  // Youngest producer first
  assign rs_val = (exm_hit_a && exm_is_alu) ? ex_mem_i.result :
                  wb_hit_a                  ? mem_wb_i.result : id_ex_i.opa;
  assign rt_val = (exm_hit_b && exm_is_alu) ? ex_mem_i.result :
                  wb_hit_b                  ? mem_wb_i.result : id_ex_i.st_data;

  // Register B only for R-type, stores keep the offset in opb
  assign alu_b = (id_ex_i.cls == CLS_ALU && id_ex_i.src_b_used) ? rt_val : id_ex_i.opb;

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:  alu_res = rs_val + alu_b;
      ALU_SUB:  alu_res = rs_val - alu_b;
      ALU_AND:  alu_res = rs_val & alu_b;
      ALU_OR:   alu_res = rs_val | alu_b;
      ALU_XOR:  alu_res = rs_val ^ alu_b;
      ALU_SLT:  alu_res = {31'b0, $signed(rs_val) < $signed(alu_b)};
      ALU_SLTU: alu_res = {31'b0, rs_val < alu_b};
      ALU_LUI:  alu_res = {alu_b[15:0], 16'h0000};
      default:  alu_res = '0;
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      ex_mem_q.cls        <= CLS_NONE;
      ex_mem_q.dest_valid <= 1'b0;
    end else if (!hold_i) begin
      ex_mem_q.cls        <= id_ex_i.valid ? id_ex_i.cls : CLS_NONE;
      ex_mem_q.result     <= alu_res;
      ex_mem_q.st_data    <= rt_val;
      ex_mem_q.dest       <= id_ex_i.dest;
      ex_mem_q.dest_valid <= id_ex_i.valid && id_ex_i.dest_valid;
    end
  end

  assign ex_mem_o = ex_mem_q;

  // Decode keeps a dependent one slot behind any load
  a_no_load_fwd: assert property (@(posedge clock_i) disable iff (rst_i)
    id_ex_i.valid && ex_mem_i.cls == CLS_LOAD |-> !exm_hit_a && !exm_hit_b);

endmodule

//--- decode/idec.sv
`timescale 1ns/10ps

module idec (
  input  logic                clock_i,
  input  logic                rst_i,
  input  logic                hold_i,
  input  pipe_pkg::if_id_t    if_id_i,
  input  pipe_pkg::word_t     rfile_rd_data1_i,
  input  pipe_pkg::word_t     rfile_rd_data2_i,
  input  pipe_pkg::mem_wb_t   mem_wb_i,
  output pipe_pkg::reg_addr_t rfile_rd_addr1_o,
  output pipe_pkg::reg_addr_t rfile_rd_addr2_o,
  output logic                load_use_o,
  output pipe_pkg::id_ex_t    id_ex_o
);
  import pipe_pkg::*;

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_ADDIU   = 6'h09,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_LUI     = 6'h0f,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_t;

  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a,
    FN_SLTU = 6'h2b
  } funct_t;

  opcode_t   opcode;
  funct_t    funct;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  logic [15:0] imm;
  word_t     rs_val;
  word_t     rt_val;
  logic      imm_sext;
  id_ex_t    dec;
  id_ex_t    id_ex_q;
  logic      wb_hit_a;
  logic      wb_hit_b;

  assign opcode = opcode_t'(if_id_i.instr[31:26]);
  assign funct  = funct_t'(if_id_i.instr[5:0]);
  assign rs     = if_id_i.instr[25:21];
  assign rt     = if_id_i.instr[20:16];
  assign rd     = if_id_i.instr[15:11];
  assign imm    = if_id_i.instr[15:0];

  assign rfile_rd_addr1_o = rs;
  assign rfile_rd_addr2_o = rt;

  // Same-cycle writeback wins over the register file
  assign rs_val = (mem_wb_i.dest_valid && mem_wb_i.dest == rs) ? mem_wb_i.result
                                                               : rfile_rd_data1_i;
  assign rt_val = (mem_wb_i.dest_valid && mem_wb_i.dest == rt) ? mem_wb_i.result
                                                               : rfile_rd_data2_i;

  always_comb begin
    dec.cls        = CLS_NONE;
    dec.alu_op     = ALU_ADD;
    dec.src_a      = rs;
    dec.src_b      = rt;
    dec.src_a_used = 1'b1;
    dec.src_b_used = 1'b0;
    dec.dest       = rt;
    imm_sext       = 1'b1;
    if (if_id_i.valid) begin
      case (opcode)
        OP_SPECIAL: begin
          dec.cls        = CLS_ALU;
          dec.src_b_used = 1'b1;
          dec.dest       = rd;
          case (funct)
            FN_ADDU: dec.alu_op = ALU_ADD;
            FN_SUBU: dec.alu_op = ALU_SUB;
            FN_AND:  dec.alu_op = ALU_AND;
            FN_OR:   dec.alu_op = ALU_OR;
            FN_XOR:  dec.alu_op = ALU_XOR;
            FN_SLT:  dec.alu_op = ALU_SLT;
            FN_SLTU: dec.alu_op = ALU_SLTU;
            default: dec.cls = CLS_NONE;
          endcase
        end
        OP_ADDIU: dec.cls = CLS_ALU;
        OP_ANDI: begin
          dec.cls    = CLS_ALU;
          dec.alu_op = ALU_AND;
          imm_sext   = 1'b0;
        end
        OP_ORI: begin
          dec.cls    = CLS_ALU;
          dec.alu_op = ALU_OR;
          imm_sext   = 1'b0;
        end
        OP_LUI: begin
          dec.cls        = CLS_ALU;
          dec.alu_op     = ALU_LUI;
          dec.src_a_used = 1'b0;
          imm_sext       = 1'b0;
        end
        OP_LW: dec.cls = CLS_LOAD;
        OP_SW: begin
          dec.cls        = CLS_STORE;
          dec.src_b_used = 1'b1;
        end
        default: dec.cls = CLS_NONE;
      endcase
    end
    dec.valid      = dec.cls != CLS_NONE;
    dec.src_a_used = dec.src_a_used & dec.valid;
    dec.src_b_used = dec.src_b_used & dec.valid;
    // r0 never gets written
    dec.dest_valid = (dec.cls == CLS_ALU || dec.cls == CLS_LOAD) && dec.dest != '0;
    dec.opa        = rs_val;
    // R-type takes register B from st_data in execute
    dec.opb        = imm_sext ? {{16{imm[15]}}, imm} : {16'h0000, imm};
    dec.st_data    = rt_val;
  end

  assign load_use_o = id_ex_q.valid && id_ex_q.cls == CLS_LOAD && id_ex_q.dest_valid &&
                      ((dec.src_a_used && dec.src_a == id_ex_q.dest) ||
                       (dec.src_b_used && dec.src_b == id_ex_q.dest));

  // A held entry catches the write that leaves MEM/WB during the stall
  assign wb_hit_a = id_ex_q.src_a_used && mem_wb_i.dest_valid && mem_wb_i.dest == id_ex_q.src_a;
  assign wb_hit_b = id_ex_q.src_b_used && mem_wb_i.dest_valid && mem_wb_i.dest == id_ex_q.src_b;

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      id_ex_q.valid      <= 1'b0;
      id_ex_q.cls        <= CLS_NONE;
      id_ex_q.dest_valid <= 1'b0;
    end else if (!hold_i) begin
      if (load_use_o) begin
        id_ex_q.valid      <= 1'b0;
        id_ex_q.cls        <= CLS_NONE;
        id_ex_q.src_a_used <= 1'b0;
        id_ex_q.src_b_used <= 1'b0;
        id_ex_q.dest_valid <= 1'b0;
      end else begin
        id_ex_q <= dec;
      end
    end else begin
      if (wb_hit_a) begin
        id_ex_q.opa <= mem_wb_i.result;
      end
      if (wb_hit_b) begin
        id_ex_q.st_data <= mem_wb_i.result;
      end
    end
  end

  assign id_ex_o = id_ex_q;

  a_no_r0_dest: assert property (@(posedge clock_i) disable iff (rst_i)
    id_ex_q.valid |-> !(id_ex_q.dest_valid && id_ex_q.dest == '0));

endmodule

//--- fetch/ifetch.sv
`timescale 1ns/10ps
`include "pipe_macros.svh"

module ifetch (
  input  logic             clock_i,
  input  logic             rst_i,
  input  logic             hold_i,
  input  pipe_pkg::word_t  icache_data_i,
  input  logic             icache_waitrequest_i,
  output pipe_pkg::word_t  icache_addr_o,
  output logic             icache_rd_o,
  output pipe_pkg::if_id_t if_id_o
);
  import pipe_pkg::*;

  word_t  pc_q;
  if_id_t if_id_q;
  logic   fetch_ok;

  assign icache_addr_o = pc_q;
  // No new read while the front end is held
  assign icache_rd_o   = ~hold_i;
  assign fetch_ok      = icache_rd_o & ~icache_waitrequest_i;

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      pc_q <= `PIPE_RESET_PC;
    end else if (fetch_ok) begin
      pc_q <= pc_q + `PIPE_XLEN'(4);
    end
  end

  // IF/ID, bubble while the icache waits
  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      if_id_q.valid <= 1'b0;
    end else if (!hold_i) begin
      if_id_q.valid <= fetch_ok;
      if_id_q.pc    <= pc_q;
      if_id_q.instr <= icache_data_i;
    end
  end

  assign if_id_o = if_id_q;

  a_pc_aligned: assert property (@(posedge clock_i) disable iff (rst_i)
    pc_q[1:0] == 2'b00);

endmodule

//--- common/pipe_pkg.sv
`include "pipe_macros.svh"

package pipe_pkg;

  typedef logic [`PIPE_XLEN-1:0]    word_t;
  typedef logic [`PIPE_RADDR_W-1:0] reg_addr_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_LUI
  } alu_op_t;

  // CLS_NONE marks a bubble
  typedef enum logic [1:0] {
    CLS_NONE,
    CLS_ALU,
    CLS_LOAD,
    CLS_STORE
  } op_class_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    logic      valid;
    op_class_t cls;
    alu_op_t   alu_op;
    word_t     opa;
    word_t     opb;
    word_t     st_data;
    reg_addr_t src_a;
    reg_addr_t src_b;
    logic      src_a_used;
    logic      src_b_used;
    reg_addr_t dest;
    logic      dest_valid;
  } id_ex_t;

  typedef struct packed {
    op_class_t cls;
    word_t     result;
    word_t     st_data;
    reg_addr_t dest;
    logic      dest_valid;
  } ex_mem_t;

  typedef struct packed {
    word_t     result;
    reg_addr_t dest;
    logic      dest_valid;
  } mem_wb_t;

endpackage

//--- common/pipe_macros.svh
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// Data and address width
`define PIPE_XLEN 32

// Register number width
`define PIPE_RADDR_W 5

// Byte enables per data word
`define PIPE_BE_W 4

// First fetch address
`define PIPE_RESET_PC 32'h0000_0000

`endif
